// File: Makefile
SIM := obj_dir/Vcpu_core_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): cpu_core.f $(wildcard source/*.sv source/*.svh sim/*.sv)
	verilator --binary --timing --assert --top-module cpu_core_tb -f cpu_core.f

clean:
	rm -rf obj_dir

// File: cpu_core.f
+incdir+source
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/cpu_core.sv
sim/cpu_core_tb.sv

// File: sim/cpu_core_tb.sv
`default_nettype none

`include "cpu_defines.svh"

module cpu_core_tb
  import cpu_pkg::*;
();

  localparam int PROG_LEN        = 60;
  localparam int NUM_INSTR       = PROG_LEN + 32;  // Random part plus register dump
  localparam int IMEM_WORDS      = 256;
  localparam int DMEM_WORDS      = 128;
  localparam int CLK_PERIOD      = 8;
  localparam int WATCHDOG_CYCLES = NUM_INSTR * 6 + 100;

  logic        clk;
  logic        reset;
  logic [31:0] inst_in;
  logic [63:0] d_in;
  wire  [31:0] pc_out;
  wire  [63:0] d_out;
  wire  [31:0] addr_out;
  wire         mem_wr_en;
  wire         mem_en;

  logic [31:0] instr_mem [0:IMEM_WORDS-1];
  logic [63:0] data_mem [0:DMEM_WORDS-1];   // Memory seen by the DUT
  logic [63:0] model_mem [0:DMEM_WORDS-1];  // Memory of the reference model
  logic [63:0] model_regs [0:31];
  logic [31:0] rng_state;
  logic [15:0] exp_addr_q [$];
  logic [63:0] exp_data_q [$];
  int          quiet_cycles;

  cpu_core uut (
    .clk       (clk),
    .reset     (reset),
    .inst_in   (inst_in),
    .d_in      (d_in),
    .pc_out    (pc_out),
    .d_out     (d_out),
    .addr_out  (addr_out),
    .mem_wr_en (mem_wr_en),
    .mem_en    (mem_en)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // 32-bit xorshift
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return next_random() % n;
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] pc);
    int unsigned idx;
    idx = pc >> 2;
    if (idx < IMEM_WORDS) begin
      return instr_mem[idx];
    end
    return `CPU_NOP_INSTR;
  endfunction

  // Lane-wise add or subtract, lanes are independent
  function automatic logic [63:0] lane_arith(input logic [63:0] a, input logic [63:0] b,
                                             input logic [1:0] ww, input logic sub);
    int unsigned lane_bits;
    logic [63:0] mask;
    logic [63:0] la;
    logic [63:0] lb;
    logic [63:0] sum;
    lane_bits = 8 << ww;
    mask = (lane_bits == 64) ? '1 : ((64'd1 << lane_bits) - 64'd1);
    sum = '0;
    for (int unsigned sh = 0; sh < 64; sh += lane_bits) begin
      la = (a >> sh) & mask;
      lb = (b >> sh) & mask;
      sum = sum | (((sub ? la - lb : la + lb) & mask) << sh);
    end
    return sum;
  endfunction

  function automatic logic [63:0] alu_model(input logic [5:0] func, input logic [1:0] ww,
                                            input logic [63:0] a, input logic [63:0] b);
    case (func)
      `FN_AND: return a & b;
      `FN_OR:  return a | b;
      `FN_XOR: return a ^ b;
      `FN_NOT: return ~a;
      `FN_MOV: return a;
      `FN_ADD: return lane_arith(a, b, ww, 1'b0);
      `FN_SUB: return lane_arith(a, b, ww, 1'b1);
      default: return '0;
    endcase
  endfunction

  // Bit 0 of the ISA is the MSB, so the "hi" part is [63:32] here
  function automatic logic [63:0] merge_part(input logic [2:0] ppp, input logic [63:0] value,
                                             input logic [63:0] old);
    case (ppp)
      `PPP_HI: return {value[63:32], old[31:0]};
      `PPP_LO: return {old[63:32], value[31:0]};
      default: return value;
    endcase
  endfunction

  task automatic build_program();
    instr_u      w;
    int unsigned kind;
    int unsigned target;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      instr_mem[i] = `CPU_NOP_INSTR;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      w = '0;
      kind = pick(20);
      if (kind < 10) begin
        w.r.opcode = `OP_ALU;
        w.r.rd     = 5'(pick(8));  // Few registers, many dependencies
        w.r.ra     = 5'(pick(8));
        w.r.rb     = 5'(pick(8));
        w.r.ppp    = 3'(pick(4));
        w.r.ww     = 2'(pick(4));
        w.r.func   = 6'(pick(9));  // 0 and 8 are unused codes
      end else if (kind < 14) begin
        w.m.opcode = `OP_LD;
        w.m.rd     = 5'(pick(8));
        w.m.imm    = 16'(pick(64));
      end else if (kind < 17) begin
        w.m.opcode = `OP_SD;
        w.m.rd     = 5'(pick(8));
        w.m.imm    = 16'(pick(64));
      end else begin
        target = i + 2 + pick(6);
        if (target > PROG_LEN) begin
          target = PROG_LEN;
        end
        w.m.opcode = (kind < 19) ? `OP_BEZ : `OP_BNEZ;
        w.m.rd     = 5'(pick(8));
        w.m.imm    = 16'(target * 4);
      end
      instr_mem[i] = w;
    end
    // Dump every register so all results become visible
    for (int r = 0; r < 32; r++) begin
      w = '0;
      w.m.opcode = `OP_SD;
      w.m.rd     = 5'(r);
      w.m.imm    = 16'(64 + r);
      instr_mem[PROG_LEN + r] = w;
    end
  endtask

  task automatic seed_data();
    logic [63:0] value;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      value = {next_random(), next_random()};
      data_mem[i]  = value;
      model_mem[i] = value;
    end
  endtask

  // Sequential ISA model, lists the stores in program order
  task automatic run_model();
    instr_u      w;
    int unsigned pc;
    int unsigned next_pc;
    logic [63:0] rt;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    pc = 0;
    while (pc < NUM_INSTR) begin
      w = instr_mem[pc];
      next_pc = pc + 1;
      rt = model_regs[w.m.rd];
      case (w.r.opcode)
        `OP_ALU: model_regs[w.r.rd] = merge_part(w.r.ppp,
                   alu_model(w.r.func, w.r.ww, model_regs[w.r.ra], model_regs[w.r.rb]),
                   model_regs[w.r.rd]);
        `OP_LD:  model_regs[w.m.rd] = model_mem[7'(w.m.imm)];
        `OP_SD: begin
          exp_addr_q.push_back(w.m.imm);
          exp_data_q.push_back(rt);
          model_mem[7'(w.m.imm)] = rt;
        end
        `OP_BEZ:  if (rt == '0) next_pc = 32'(w.m.imm) >> 2;
        `OP_BNEZ: if (rt != '0) next_pc = 32'(w.m.imm) >> 2;
        default: begin
        end
      endcase
      pc = next_pc;
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("mismatch at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic check_store();
    assert (exp_addr_q.size() > 0) else begin
      $display("store to address %h at time %0t after the last expected store", addr_out, $time);
      $display("STATUS: FAIL");
      $fatal(1, "unexpected store");
    end
    check_value("mem_en", 64'(1'b1), 64'(mem_en));
    check_value("addr_out", 64'(exp_addr_q[0]), 64'(addr_out));
    check_value("d_out", exp_data_q[0], d_out);
    data_mem[7'(addr_out)] = d_out;
    void'(exp_addr_q.pop_front());
    void'(exp_data_q.pop_front());
  endtask

  // Memories act on the strobes seen after each edge
  task automatic service_cycle();
    if (mem_wr_en) begin
      check_store();
    end
    if (mem_en && !mem_wr_en) begin
      d_in = data_mem[7'(addr_out)];  // Valid while the load is in WB
    end else begin
      d_in = '0;
    end
    inst_in = fetch_word(pc_out);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, store sequence not finished", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rng_state = 32'd8567;
    build_program();
    seed_data();
    run_model();
    reset   = 1'b1;
    d_in    = '0;
    inst_in = fetch_word(32'd0);
    $display("expecting %0d stores", exp_addr_q.size());

    repeat (5) @(posedge clk);
    #1;
    check_value("pc_out", 64'd0, 64'(pc_out));
    check_value("mem_en", 64'd0, 64'(mem_en));
    check_value("mem_wr_en", 64'd0, 64'(mem_wr_en));
    reset = 1'b0;

    quiet_cycles = 0;
    while (exp_addr_q.size() > 0 || quiet_cycles < 20) begin
      @(posedge clk);
      #1;
      service_cycle();
      if (exp_addr_q.size() == 0 && !mem_wr_en) begin
        quiet_cycles++;
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/alu.sv
`default_nettype none

`include "cpu_defines.svh"

module alu (
  input  wire [0:`CPU_XLEN-1]  op_a,
  input  wire [0:`CPU_XLEN-1]  op_b,
  input  wire [0:5]            func,
  input  wire [0:1]            ww,
  output logic [0:`CPU_XLEN-1] result
);

  logic                 is_sub;
  logic [0:`CPU_XLEN-1] addend;
  logic [0:`CPU_XLEN-1] lane_sum;
  logic [2:0]           lane_mask;
  logic                 carry;

  assign is_sub = (func == `FN_SUB);
  assign addend = is_sub ? ~op_b : op_b;  // a - b as a + ~b + 1

  // Low byte-index bits that stay inside one lane
  always_comb begin
    case (ww)
      `WW_B: lane_mask = 3'b000;
      `WW_H: lane_mask = 3'b001;
      `WW_W: lane_mask = 3'b011;
      `WW_D: lane_mask = 3'b111;
    endcase
  end

  // Byte-wise ripple, carry cut at each lane boundary
  always_comb begin
    carry    = is_sub;
    lane_sum = '0;
    for (int j = 0; j < 8; j++) begin
      if ((3'(j) & lane_mask) == 3'd0) begin
        carry = is_sub;  // First byte of a lane
      end
      {carry, lane_sum[(7 - j) * 8 +: 8]} = {1'b0, op_a[(7 - j) * 8 +: 8]}
                                          + {1'b0, addend[(7 - j) * 8 +: 8]}
                                          + {8'd0, carry};
    end
  end

  always_comb begin
    case (func)
      `FN_AND: result = op_a & op_b;
      `FN_OR:  result = op_a | op_b;
      `FN_XOR: result = op_a ^ op_b;
      `FN_NOT: result = ~op_a;
      `FN_MOV: result = op_a;
      `FN_ADD: result = lane_sum;
      `FN_SUB: result = lane_sum;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/cpu_core.sv
`default_nettype none

`include "cpu_defines.svh"

module cpu_core
  import cpu_pkg::*;
(
  input  wire                   clk,
  input  wire                   reset,
  input  wire [0:`CPU_ILEN-1]   inst_in,
  input  wire [0:`CPU_XLEN-1]   d_in,
  output wire [0:31]            pc_out,
  output wire [0:`CPU_XLEN-1]   d_out,
  output wire [0:31]            addr_out,
  output wire                   mem_wr_en,
  output wire                   mem_en
);

  // Fetch and decode
  instr_u                 if_instr;
  wire                    stall;
  wire                    branch_taken;
  wire [0:31]             branch_target;

  // Register file ports
  wire [0:`CPU_RADDR-1]   ra_addr;
  wire [0:`CPU_RADDR-1]   rb_addr;
  wire [0:`CPU_RADDR-1]   rt_addr;
  wire [0:`CPU_XLEN-1]    ra_data;
  wire [0:`CPU_XLEN-1]    rb_data;
  wire [0:`CPU_XLEN-1]    rt_data;

  // ID/EX
  wire                    ex_valid;
  wire                    ex_alu;
  wire                    ex_ld;
  wire                    ex_sd;
  wire [0:5]              ex_func;
  wire [0:1]              ex_ww;
  wire [0:2]              ex_ppp;
  wire [0:`CPU_RADDR-1]   ex_rd;
  wire [0:`CPU_RADDR-1]   ex_ra;
  wire [0:`CPU_RADDR-1]   ex_rb;
  wire [0:15]             ex_imm;
  wire [0:`CPU_XLEN-1]    ex_ra_data;
  wire [0:`CPU_XLEN-1]    ex_rb_data;

  // Writeback
  wire                    wb_we;
  wire [0:`CPU_RADDR-1]   wb_rd;
  wire [0:2]              wb_ppp;
  wire [0:`CPU_XLEN-1]    wb_data;

  // Port names match the wires above throughout
  fetch_stage u_fetch (.*);

  decode_stage u_decode (.*);

  register_file u_regs (.*);

  execute_stage u_execute (.*);

endmodule

`default_nettype wire

// File: source/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_XLEN  64
`define CPU_ILEN  32
`define CPU_NREGS 32
`define CPU_RADDR 5

// Opcodes, always in bits 0..5
`define OP_ALU  6'b101010
`define OP_LD   6'b100000
`define OP_SD   6'b100001
`define OP_BEZ  6'b100010
`define OP_BNEZ 6'b100011
`define OP_NOP  6'b111100

// ALU function codes
`define FN_AND 6'b000001
`define FN_OR  6'b000010
`define FN_XOR 6'b000011
`define FN_NOT 6'b000100
`define FN_MOV 6'b000101
`define FN_ADD 6'b000110
`define FN_SUB 6'b000111

// Lane widths 8/16/32/64
`define WW_B 2'b00
`define WW_H 2'b01
`define WW_W 2'b10
`define WW_D 2'b11

`define PPP_ALL 3'b000
`define PPP_HI  3'b001  // Bits 0..31, the upper half
`define PPP_LO  3'b010  // Bits 32..63

`define CPU_NOP_INSTR {`OP_NOP, 26'd0}

`endif

// File: source/cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

  // Register format, used by ALU operations
  typedef struct packed {
    logic [0:5]            opcode;
    logic [0:`CPU_RADDR-1] rd;
    logic [0:`CPU_RADDR-1] ra;
    logic [0:`CPU_RADDR-1] rb;
    logic [0:2]            ppp;
    logic [0:1]            ww;
    logic [0:5]            func;
  } instr_r_t;

  // Memory and branch format
  typedef struct packed {
    logic [0:5]            opcode;
    logic [0:`CPU_RADDR-1] rd;
    logic [0:`CPU_RADDR-1] ra;   // Not used
    logic [0:15]           imm;
  } instr_m_t;

  typedef union packed {
    instr_r_t r;
    instr_m_t m;
  } instr_u;

  // Applies a partial write on top of the old register value
  function automatic logic [0:`CPU_XLEN-1] ppp_merge(input logic [0:2] ppp,
                                                     input logic [0:`CPU_XLEN-1] new_val,
                                                     input logic [0:`CPU_XLEN-1] old_val);
    case (ppp)
      `PPP_HI: return {new_val[0:`CPU_XLEN/2-1], old_val[`CPU_XLEN/2:`CPU_XLEN-1]};
      `PPP_LO: return {old_val[0:`CPU_XLEN/2-1], new_val[`CPU_XLEN/2:`CPU_XLEN-1]};
      default: return new_val;  // PPP_ALL and unused codes
    endcase
  endfunction

endpackage

`default_nettype wire

// File: source/decode_stage.sv
`default_nettype none

`include "cpu_defines.svh"

module decode_stage
  import cpu_pkg::*;
(
  input  wire                    clk,
  input  wire                    reset,
  input  wire instr_u            if_instr,
  input  wire [0:`CPU_XLEN-1]    ra_data,
  input  wire [0:`CPU_XLEN-1]    rb_data,
  input  wire [0:`CPU_XLEN-1]    rt_data,
  output logic [0:`CPU_RADDR-1]  ra_addr,
  output logic [0:`CPU_RADDR-1]  rb_addr,
  output logic [0:`CPU_RADDR-1]  rt_addr,
  output logic                   stall,
  output logic                   branch_taken,
  output logic [0:31]            branch_target,
  output logic                   ex_valid,
  output logic                   ex_alu,
  output logic                   ex_ld,
  output logic                   ex_sd,
  output logic [0:5]             ex_func,
  output logic [0:1]             ex_ww,
  output logic [0:2]             ex_ppp,
  output logic [0:`CPU_RADDR-1]  ex_rd,
  output logic [0:`CPU_RADDR-1]  ex_ra,
  output logic [0:`CPU_RADDR-1]  ex_rb,
  output logic [0:15]            ex_imm,
  output logic [0:`CPU_XLEN-1]   ex_ra_data,
  output logic [0:`CPU_XLEN-1]   ex_rb_data
);

  logic [0:5] opcode;
  logic       is_alu;
  logic       is_ld;
  logic       is_sd;
  logic       is_bez;
  logic       is_bnez;
  logic       rt_zero;

  assign opcode  = if_instr.r.opcode;  // Same place in both formats
  assign is_alu  = (opcode == `OP_ALU);
  assign is_ld   = (opcode == `OP_LD);
  assign is_sd   = (opcode == `OP_SD);
  assign is_bez  = (opcode == `OP_BEZ);
  assign is_bnez = (opcode == `OP_BNEZ);

  assign ra_addr = if_instr.r.ra;
  assign rb_addr = is_sd ? if_instr.m.rd : if_instr.r.rb;  // Store data is rD
  assign rt_addr = if_instr.m.rd;

  // Test register still being produced in EX
  assign stall = (is_bez || is_bnez) && (ex_alu || ex_ld) && (ex_rd == rt_addr);

  assign rt_zero       = (rt_data == '0);
  assign branch_taken  = !stall && ((is_bez && rt_zero) || (is_bnez && !rt_zero));
  assign branch_target = {16'd0, if_instr.m.imm};

  // ID/EX control with a bubble on stall
  always_ff @(posedge clk) begin
    if (reset || stall) begin
      ex_valid <= 1'b0;
      ex_alu   <= 1'b0;
      ex_ld    <= 1'b0;
      ex_sd    <= 1'b0;
    end else begin
      ex_valid <= 1'b1;
      ex_alu   <= is_alu;
      ex_ld    <= is_ld;
      ex_sd    <= is_sd;
    end
  end

  always_ff @(posedge clk) begin
    ex_func    <= if_instr.r.func;
    ex_ww      <= if_instr.r.ww;
    ex_ppp     <= is_alu ? if_instr.r.ppp : `PPP_ALL;  // Loads write the whole register
    ex_rd      <= if_instr.r.rd;
    ex_ra      <= ra_addr;
    ex_rb      <= rb_addr;
    ex_imm     <= if_instr.m.imm;
    ex_ra_data <= ra_data;
    ex_rb_data <= rb_data;
  end

  a_ex_class_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0({ex_alu, ex_ld, ex_sd}));

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`default_nettype none

`include "cpu_defines.svh"

module execute_stage
  import cpu_pkg::*;
(
  input  wire                    clk,
  input  wire                    reset,
  input  wire [0:`CPU_XLEN-1]    d_in,
  input  wire                    ex_valid,
  input  wire                    ex_alu,
  input  wire                    ex_ld,
  input  wire                    ex_sd,
  input  wire [0:5]              ex_func,
  input  wire [0:1]              ex_ww,
  input  wire [0:2]              ex_ppp,
  input  wire [0:`CPU_RADDR-1]   ex_rd,
  input  wire [0:`CPU_RADDR-1]   ex_ra,
  input  wire [0:`CPU_RADDR-1]   ex_rb,
  input  wire [0:15]             ex_imm,
  input  wire [0:`CPU_XLEN-1]    ex_ra_data,
  input  wire [0:`CPU_XLEN-1]    ex_rb_data,
  output logic [0:`CPU_XLEN-1]   d_out,
  output logic [0:31]            addr_out,
  output logic                   mem_en,
  output logic                   mem_wr_en,
  output logic                   wb_we,
  output logic [0:`CPU_RADDR-1]  wb_rd,
  output logic [0:2]             wb_ppp,
  output logic [0:`CPU_XLEN-1]   wb_data
);

  logic [0:`CPU_XLEN-1] op_a;
  logic [0:`CPU_XLEN-1] op_b;
  logic [0:`CPU_XLEN-1] alu_result;
  logic [0:`CPU_XLEN-1] alu_result_q;
  logic                 wb_ld;

  // WB forwarding; a partial write only replaces its half of the old operand
  assign op_a = (wb_we && wb_rd == ex_ra) ? ppp_merge(wb_ppp, wb_data, ex_ra_data)
                                          : ex_ra_data;
  assign op_b = (wb_we && wb_rd == ex_rb) ? ppp_merge(wb_ppp, wb_data, ex_rb_data)
                                          : ex_rb_data;

  alu u_alu (
    .op_a   (op_a),
    .op_b   (op_b),
    .func   (ex_func),
    .ww     (ex_ww),
    .result (alu_result)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_en    <= 1'b0;
      mem_wr_en <= 1'b0;
      wb_we     <= 1'b0;
      wb_ld     <= 1'b0;
    end else begin
      mem_en    <= ex_valid && (ex_ld || ex_sd);
      mem_wr_en <= ex_valid && ex_sd;
      wb_we     <= ex_valid && (ex_alu || ex_ld);
      wb_ld     <= ex_valid && ex_ld;
    end
  end

  always_ff @(posedge clk) begin
    addr_out     <= {16'd0, ex_imm};
    d_out        <= op_b;  // rD of a store, read through port B
    wb_rd        <= ex_rd;
    wb_ppp       <= ex_ppp;
    alu_result_q <= alu_result;
  end

  // Load data arrives from memory while the load sits in WB
  assign wb_data = wb_ld ? d_in : alu_result_q;

  a_wr_needs_en: assert property (@(posedge clk) disable iff (reset)
    mem_wr_en |-> mem_en);

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`default_nettype none

`include "cpu_defines.svh"

module fetch_stage
  import cpu_pkg::*;
(
  input  wire                  clk,
  input  wire                  reset,
  input  wire [0:`CPU_ILEN-1]  inst_in,
  input  wire                  stall,
  input  wire                  branch_taken,
  input  wire [0:31]           branch_target,
  output logic [0:31]          pc_out,
  output instr_u               if_instr
);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_out   <= '0;
      if_instr <= `CPU_NOP_INSTR;
    end else if (branch_taken) begin
      pc_out   <= branch_target;
      if_instr <= `CPU_NOP_INSTR;  // Squash the word behind the branch
    end else if (!stall) begin
      pc_out   <= pc_out + 32'd4;
      if_instr <= inst_in;
    end
    // On stall both pc and instruction hold
  end

  // Targets come from decode, so they must keep the pc aligned too
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    pc_out[30:31] == 2'b00);

endmodule

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

`include "cpu_defines.svh"

module register_file
  import cpu_pkg::*;
(
  input  wire                    clk,
  input  wire                    reset,
  input  wire [0:`CPU_RADDR-1]   ra_addr,
  input  wire [0:`CPU_RADDR-1]   rb_addr,
  input  wire [0:`CPU_RADDR-1]   rt_addr,
  input  wire                    wb_we,
  input  wire [0:`CPU_RADDR-1]   wb_rd,
  input  wire [0:2]              wb_ppp,
  input  wire [0:`CPU_XLEN-1]    wb_data,
  output logic [0:`CPU_XLEN-1]   ra_data,
  output logic [0:`CPU_XLEN-1]   rb_data,
  output logic [0:`CPU_XLEN-1]   rt_data
);

  logic [0:`CPU_XLEN-1] regs [0:`CPU_NREGS-1];
  logic [0:`CPU_XLEN-1] wr_value;

  assign wr_value = ppp_merge(wb_ppp, wb_data, regs[wb_rd]);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we) begin
      regs[wb_rd] <= wr_value;
    end
  end

  // Write-through so decode sees this cycle's writeback
  assign ra_data = (wb_we && wb_rd == ra_addr) ? wr_value : regs[ra_addr];
  assign rb_data = (wb_we && wb_rd == rb_addr) ? wr_value : regs[rb_addr];
  assign rt_data = (wb_we && wb_rd == rt_addr) ? wr_value : regs[rt_addr];

endmodule

`default_nettype wire
